//--- filelist.f
div_pkg.sv
div_req_if.sv
div_dispatch.sv
div_lane.sv
div_collect.sv
div_unit.sv
tb_div_unit.sv

//--- Makefile
# Verilator build and run for the divide unit
VERILATOR ?= verilator
TOP       ?= tb_div_unit
RTL_TOP   ?= div_unit
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

FAIL_MSG := Finished with errors
PASS_MSG := Finished with no errors

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not finish"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_div_unit.sv
// testbench for the divide unit with four lanes
// results are checked against a reference model in acceptance order
// out_ready is pulled low at random in the second random phase
// the run stops at the first mismatch
`timescale 1ns/100ps
`default_nettype none

module tb_div_unit;
    import div_pkg::*;

    localparam int num_lanes = 4;
    localparam int n_rand    = 200;
    localparam int total_ops = 16 + 2 * n_rand;
    localparam longint timeout_ns = (longint'(total_ops) * 200 + 16) * 40;
    localparam logic [63:0] min64 = 64'h8000_0000_0000_0000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    div_op_e     in_op;
    logic [63:0] in_a;
    logic [63:0] in_b;
    logic        out_valid;
    logic        out_ready;
    logic [63:0] out_data;

    logic [31:0] stim_lfsr;
    logic [31:0] ready_lfsr;
    logic        stall_mode;
    logic [63:0] exp_q [$];
    logic [63:0] exp_head;
    int          exp_count;

    div_unit #(.NUM_LANES(num_lanes)) div_unit_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_op     (in_op),
        .in_a      (in_a),
        .in_b      (in_b),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #20 clk = ~clk;

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic fail_value(string name, logic [63:0] expected, logic [63:0] actual);
        $display("FAIL at %0t: %s expected %h got %h", $time, name, expected, actual);
        abort_run();
    endtask

    task automatic fail_run(string what);
        $display("ERROR at %0t: %s", $time, what);
        abort_run();
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[62:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    // RISC-V M results worked out with plain arithmetic
    function automatic logic [63:0] ref_result(div_op_e op, logic [63:0] a, logic [63:0] b);
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] q;
        logic [63:0] r;
        logic [63:0] res;
        x = a;
        y = b;
        if (op_is_word(op)) begin
            x = op_is_signed(op) ? {{32{a[31]}}, a[31:0]} : {32'h0, a[31:0]};
            y = op_is_signed(op) ? {{32{b[31]}}, b[31:0]} : {32'h0, b[31:0]};
        end
        if (y == '0) begin
            q = '1;
            r = x;
        end else if (op_is_signed(op) && x == min64 && y == '1) begin
            q = x;
            r = '0;
        end else if (op_is_signed(op)) begin
            q = $signed(x) / $signed(y);   // truncates toward zero
            r = $signed(x) % $signed(y);
        end else begin
            q = x / y;
            r = x % y;
        end
        res = op_is_rem(op) ? r : q;
        if (op_is_word(op)) begin
            res = {{32{res[31]}}, res[31:0]};
        end
        return res;
    endfunction

    // call at 2 ns after a rising edge, returns 2 ns after the accepting edge
    task automatic send(div_op_e op, logic [63:0] a, logic [63:0] b);
        in_valid = 1'b1;
        in_op    = op;
        in_a     = a;
        in_b     = b;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic send_random();
        div_op_e     op;
        logic [63:0] a;
        logic [63:0] b;
        op = div_op_e'(rand_bits(3));
        a  = rand_bits(64);
        b  = rand_bits(64) >> rand_bits(6);   // spread of quotient sizes
        if (rand_bits(1) == 64'd1) begin
            b = -b;
        end
        send(op, a, b);
    endtask

    // scoreboard: push on acceptance, pop on output transfer
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_q.delete();
            exp_head  <= '0;
            exp_count <= 0;
        end else begin
            if (out_valid && out_ready && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(ref_result(in_op, in_a, in_b));
            end
            exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
            exp_count <= exp_q.size();
        end
    end

    always @(posedge clk) begin
        #2;
        if (stall_mode) begin
            ready_lfsr = lfsr_next(ready_lfsr);
            out_ready  = ready_lfsr[0];
        end else begin
            out_ready = 1'b1;
        end
    end

    a_out_known: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> exp_count > 0)
        else fail_run("out_valid high with no request outstanding");

    a_out_data: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_data == exp_head)
        else fail_value("out_data", $sampled(exp_head), $sampled(out_data));

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else fail_run("out_valid dropped or out_data changed while out_ready was low");

    a_full: assert property (@(posedge clk) disable iff (!rst_n)
        exp_count >= num_lanes |-> !in_ready)
        else fail_run("in_ready high while every lane holds an operation");

    initial begin
        #(timeout_ns);
        fail_run("timeout, not all results arrived in time");
    end

    initial begin
        stim_lfsr  = 32'd97762;
        ready_lfsr = 32'd97762;
        stall_mode = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_op      = op_div;
        in_a       = '0;
        in_b       = '0;
        out_ready  = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        a_reset: assert (in_ready === 1'b1 && out_valid === 1'b0)
            else fail_run("in_ready low or out_valid high just after reset");
        @(posedge clk);
        #2;
        for (int k = 0; k < 8; k++) begin
            // word ops see a zero low half under random upper bits
            send(div_op_e'(k), rand_bits(64),
                 op_is_word(div_op_e'(k)) ? {32'(rand_bits(32)), 32'h0} : 64'h0);
        end
        for (int k = 0; k < 8; k++) begin
            if (op_is_word(div_op_e'(k))) begin
                send(div_op_e'(k), {32'(rand_bits(32)), 32'h8000_0000},
                     {32'(rand_bits(32)), 32'hffff_ffff});
            end else begin
                send(div_op_e'(k), min64, '1);
            end
        end
        for (int i = 0; i < n_rand; i++) begin
            send_random();
        end
        stall_mode = 1'b1;
        for (int i = 0; i < n_rand; i++) begin
            send_random();
        end
        while (exp_count != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        if (exp_count == 0 && !out_valid) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            fail_run("results left over at the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- div_unit.sv
// RV64M divide unit: div, divu, rem, remu and the word forms
// NUM_LANES restoring lanes, valid for 1 to 8, results in acceptance order
// fixed latency of 66 cycles from acceptance to out_valid when not stalled
// no multiply, no early termination, no tags
`timescale 1ns/100ps
`default_nettype none

module div_unit #(
    parameter int NUM_LANES = div_pkg::num_lanes_default
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       in_valid,
    output logic                      in_ready,
    input  wire  div_pkg::div_op_e    in_op,
    input  wire  [div_pkg::xlen-1:0]  in_a,
    input  wire  [div_pkg::xlen-1:0]  in_b,
    output logic                      out_valid,
    input  wire                       out_ready,
    output logic [div_pkg::xlen-1:0]  out_data
);
    import div_pkg::*;

    div_req_if up_if ();
    div_req_if lane_if [NUM_LANES] ();

    logic [NUM_LANES-1:0] rsp_valid;
    logic [NUM_LANES-1:0] rsp_ready;
    logic [xlen-1:0]      rsp_data [NUM_LANES];

    assign up_if.valid = in_valid;
    assign up_if.op    = in_op;
    assign up_if.a     = in_a;
    assign up_if.b     = in_b;
    assign in_ready    = up_if.ready;

    div_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (up_if),
        .lanes (lane_if)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        div_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .req       (lane_if[i]),
            .rsp_valid (rsp_valid[i]),
            .rsp_ready (rsp_ready[i]),
            .rsp_data  (rsp_data[i])
        );
    end

    div_collect #(.NUM_LANES(NUM_LANES)) u_collect (
        .clk       (clk),
        .rst_n     (rst_n),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

//--- div_collect.sv
// round-robin drain of lane results in the same fixed order as issue
// routing is combinational, only the lane named by the pointer is visible
// a lane that is not ready yet blocks the output, later lanes wait behind it
`timescale 1ns/100ps
`default_nettype none

module div_collect #(
    parameter int NUM_LANES = div_pkg::num_lanes_default
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire  [NUM_LANES-1:0]      rsp_valid,
    output logic [NUM_LANES-1:0]      rsp_ready,
    input  wire  [div_pkg::xlen-1:0]  rsp_data [NUM_LANES],
    output logic                      out_valid,
    input  wire                       out_ready,
    output logic [div_pkg::xlen-1:0]  out_data
);

    localparam int ptr_w = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [ptr_w-1:0] ptr;             // lane whose result leaves next

    assign out_valid = rsp_valid[ptr];
    assign out_data  = rsp_data[ptr];

    always_comb begin
        rsp_ready      = '0;
        rsp_ready[ptr] = out_ready;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (out_valid && out_ready) begin
            if (ptr == ptr_w'(NUM_LANES - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- div_lane.sv
// one restoring divider lane, one quotient bit per cycle, no early exit
// rsp_valid rises exactly 66 cycles after the accepting edge
// sequence is capture, prepare, 64 steps, fixup, then hold until rsp_ready
// divide by zero and signed overflow follow the RISC-V results
`timescale 1ns/100ps
`default_nettype none

module div_lane (
    input  wire                       clk,
    input  wire                       rst_n,
    div_req_if.snk                    req,
    output logic                      rsp_valid,
    input  wire                       rsp_ready,
    output logic [div_pkg::xlen-1:0]  rsp_data
);
    import div_pkg::*;

    localparam int step_w = $clog2(xlen);

    typedef enum logic [2:0] {
        st_idle,
        st_prep,
        st_run,
        st_fix,
        st_done
    } state_e;

    state_e              state;
    logic [step_w-1:0]   step;
    div_op_e             op_q;
    logic [xlen-1:0]     a_x;          // operands after word extension
    logic [xlen-1:0]     b_x;
    logic [xlen-1:0]     dvs;          // divisor magnitude
    logic [2*xlen-1:0]   rq;           // partial remainder high, quotient low
    logic                neg_q;        // result must be negated
    logic                dz_q;
    logic                ovf_q;
    logic [xlen-1:0]     res_q;

    logic                sgn;
    logic                a_neg;
    logic                b_neg;
    logic                min_a;
    logic [xlen:0]       trial;
    logic [xlen+1:0]     diff;
    logic [xlen-1:0]     pick;
    logic [xlen-1:0]     fixed;

    assign req.ready = (state == st_idle);
    assign rsp_valid = (state == st_done);
    assign rsp_data  = res_q;

    assign sgn   = op_is_signed(op_q);
    assign a_neg = sgn && a_x[xlen-1];
    assign b_neg = sgn && b_x[xlen-1];
    assign min_a = op_is_word(op_q) ? (a_x[31:0] == 32'h8000_0000)
                                    : (a_x == {1'b1, {(xlen-1){1'b0}}});

    // shifted remainder with the next dividend bit, 65 bits wide
    assign trial = rq[2*xlen-1:xlen-1];
    assign diff  = {1'b0, trial} - {2'b00, dvs};

    always_comb begin
        pick = op_is_rem(op_q) ? rq[2*xlen-1:xlen] : rq[xlen-1:0];
        pick = magnitude(neg_q, pick);
        if (dz_q) begin
            pick = op_is_rem(op_q) ? a_x : '1;
        end else if (ovf_q) begin
            pick = op_is_rem(op_q) ? '0 : a_x;
        end
        fixed = op_is_word(op_q) ? {{(xlen-32){pick[31]}}, pick[31:0]} : pick;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            step  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (req.valid) begin
                        state <= st_prep;
                    end
                end
                st_prep: begin
                    state <= st_run;
                    step  <= '0;
                end
                st_run: begin
                    step <= step + 1'b1;
                    if (step == step_w'(xlen - 1)) begin
                        state <= st_fix;
                    end
                end
                st_fix: state <= st_done;
                st_done: begin
                    if (rsp_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (req.valid) begin
                    op_q <= req.op;
                    a_x  <= prep_operand(req.op, req.a);
                    b_x  <= prep_operand(req.op, req.b);
                end
            end
            st_prep: begin
                rq    <= {{xlen{1'b0}}, magnitude(a_neg, a_x)};
                dvs   <= magnitude(b_neg, b_x);
                neg_q <= op_is_rem(op_q) ? a_neg : (a_neg ^ b_neg);
                dz_q  <= (b_x == '0);
                ovf_q <= sgn && min_a && (b_x == '1);
            end
            st_run: begin
                if (diff[xlen+1]) begin
                    rq <= {rq[2*xlen-2:0], 1'b0};                     // restore
                end else begin
                    rq <= {diff[xlen-1:0], rq[xlen-2:0], 1'b1};
                end
            end
            st_fix: res_q <= fixed;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- div_dispatch.sv
// round-robin issue of divide requests to the lanes in fixed order
// routing is combinational, no latency is added on the request path
// when the next lane in turn is busy the request waits, no lane is skipped
`timescale 1ns/100ps
`default_nettype none

module div_dispatch #(
    parameter int NUM_LANES = div_pkg::num_lanes_default
) (
    input  wire       clk,
    input  wire       rst_n,
    div_req_if.snk    up,
    div_req_if.src    lanes [NUM_LANES]
);

    localparam int ptr_w = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [ptr_w-1:0]     ptr;         // lane that takes the next request
    logic [NUM_LANES-1:0] lane_ready;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign lanes[i].valid = up.valid && (ptr == ptr_w'(i));
        assign lanes[i].op    = up.op;
        assign lanes[i].a     = up.a;
        assign lanes[i].b     = up.b;
        assign lane_ready[i]  = lanes[i].ready;
    end

    assign up.ready = lane_ready[ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (up.valid && up.ready) begin
            if (ptr == ptr_w'(NUM_LANES - 1)) begin
                ptr <= '0;     // wrap
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- div_req_if.sv
// one divide request with a valid/ready handshake
// a transfer happens on a rising edge with valid and ready both high
// the source holds op, a and b steady while valid is high and ready is low
`timescale 1ns/100ps
`default_nettype none

interface div_req_if;
    import div_pkg::*;

    logic            valid;
    logic            ready;
    div_op_e         op;
    logic [xlen-1:0] a;        // dividend
    logic [xlen-1:0] b;        // divisor

    modport src (
        output valid,
        output op,
        output a,
        output b,
        input  ready
    );

    modport snk (
        input  valid,
        input  op,
        input  a,
        input  b,
        output ready
    );

endinterface

`default_nettype wire

//--- div_pkg.sv
// shared definitions for the RV64M divide unit
// operation codes are local to this unit, they are not ISA funct3 values
// bit 0 set means unsigned, bit 1 set means remainder, bit 2 set means word
`default_nettype none

package div_pkg;

    localparam int xlen = 64;
    localparam int num_lanes_default = 4;

    typedef enum logic [2:0] {
        op_div   = 3'd0,
        op_divu  = 3'd1,
        op_rem   = 3'd2,
        op_remu  = 3'd3,
        op_divw  = 3'd4,
        op_divuw = 3'd5,
        op_remw  = 3'd6,
        op_remuw = 3'd7
    } div_op_e;

    function automatic logic op_is_signed(div_op_e op);
        return !op[0];
    endfunction

    function automatic logic op_is_rem(div_op_e op);
        return op[1];
    endfunction

    function automatic logic op_is_word(div_op_e op);
        return op[2];
    endfunction

    // word ops keep the low half, extended by the signedness of the op
    function automatic logic [xlen-1:0] prep_operand(div_op_e op, logic [xlen-1:0] x);
        if (!op_is_word(op)) begin
            return x;
        end
        if (op_is_signed(op)) begin
            return {{(xlen-32){x[31]}}, x[31:0]};
        end
        return {{(xlen-32){1'b0}}, x[31:0]};
    endfunction

    function automatic logic [xlen-1:0] magnitude(logic neg, logic [xlen-1:0] x);
        return neg ? -x : x;   // two's complement negate when neg
    endfunction

endpackage

`default_nettype wire
